// ==== Makefile ====
TOP = tb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== design/gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_port import io_pkg::*; #(
  parameter int GPIO_W = 16
) (
  input  logic              clk,
  input  logic              resetq,
  io_bus_if.dst             bus,
  input  io_word_t          mask,
  input  logic [GPIO_W-1:0] gpio_in,
  output logic [GPIO_W-1:0] gpio_out,
  output logic [GPIO_W-1:0] gpio_oe,   // 1 = pin drives
  output io_word_t          rdata
);

  logic [GPIO_W-1:0] wmask;
  logic [GPIO_W-1:0] wd;
  logic              we_data;
  logic              we_dir;
  io_word_t          in_word;
  io_word_t          oe_word;

  assign wmask   = mask[GPIO_W-1:0];      // port may be narrower than a word
  assign wd      = bus.wdata[GPIO_W-1:0];
  assign we_data = bus.wr & bus.addr[IO_BIT_GPIO_DATA];
  assign we_dir  = bus.wr & bus.addr[IO_BIT_GPIO_DIR];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      gpio_out <= '0;
      gpio_oe  <= '0;   // all pins input after reset
    end else begin
      // unmasked bits take the pin value, like the old sb_io port
      if (we_data)
        gpio_out <= (wd & wmask) | (gpio_in & ~wmask);
      // direction only moves under the mask, lets threads share the port
      if (we_dir)
        gpio_oe <= (wd & wmask) | (gpio_oe & ~wmask);
    end
  end

  assign in_word = io_word_t'(gpio_in);   // zero extend
  assign oe_word = io_word_t'(gpio_oe);

  // read contribution, gated by own address bits
  assign rdata = (bus.addr[IO_BIT_GPIO_DATA] ? in_word : '0) |
                 (bus.addr[IO_BIT_GPIO_DIR]  ? oe_word : '0);

endmodule

`default_nettype wire

// ==== design/io_access_mask.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_access_mask import io_pkg::*; #(
  parameter int NUM_SLOTS = 4
) (
  input  logic     clk,
  input  logic     resetq,
  io_bus_if.dst    bus,
  input  io_word_t gpio_rdata,   // already gated by gpio address bits
  input  io_word_t task_rdata,   // already gated by task address bits
  output io_word_t mask,         // mask of the slot on the bus
  output io_word_t rdata
);

  io_word_t preset [NUM_SLOTS];  // one mask per thread slot
  io_word_t slot_id;
  io_word_t read_or;

  // mask set by a write to bit 15 lasts for that slot's next access only
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        preset[i] <= IO_MASK_ALL;
      end
    end else if (bus.rd | bus.wr) begin
      if (bus.wr & bus.addr[IO_BIT_MASK_SLOT])
        preset[bus.slot] <= bus.wdata;    // arm mask for next access
      else
        preset[bus.slot] <= IO_MASK_ALL;  // used up, back to all ones
    end
  end

  // other slots keep their own preset
  assign mask = preset[bus.slot];

  // slot id read, depends only on who asks
  assign slot_id = bus.addr[IO_BIT_MASK_SLOT] ? io_word_t'(bus.slot) : '0;

  assign read_or = gpio_rdata | task_rdata | slot_id;

  // cleared mask bits read as zero
  assign rdata = read_or & mask;

endmodule

`default_nettype wire

// ==== design/io_access_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_access_stage import io_pkg::*; #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                         clk,
  input  logic                         resetq,
  input  logic                         io_rd,
  input  logic                         io_wr,
  input  io_word_t                     io_addr,
  input  io_word_t                     io_wdata,
  input  logic [$clog2(NUM_SLOTS)-1:0] io_slot,
  io_bus_if.src                        bus
);

  // strobes and address, cleared on reset
  always_ff @(posedge clk) begin
    if (!resetq) begin
      bus.rd   <= 1'b0;
      bus.wr   <= 1'b0;
      bus.addr <= '0;
    end else begin
      bus.rd <= io_rd;
      bus.wr <= io_wr;
      // no strobe, no address, so an idle cycle can't hit a register
      bus.addr <= (io_rd | io_wr) ? io_addr : '0;
    end
  end

  // payload rides along
  always_ff @(posedge clk) begin
    bus.wdata <= io_wdata;
    bus.slot  <= io_slot;
  end

endmodule

`default_nettype wire

// ==== design/io_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// registered i/o access, one strobe = one access, no wait states
interface io_bus_if import io_pkg::*; #(
  parameter int NUM_SLOTS = 4
) ();

  localparam int SLOT_W = $clog2(NUM_SLOTS);

  logic              rd;     // read strobe, one cycle
  logic              wr;     // write strobe, one cycle
  io_word_t          addr;   // one-hot, zero when idle
  io_word_t          wdata;
  logic [SLOT_W-1:0] slot;   // thread slot that made the access

  // access stage side
  modport src (output rd, wr, addr, wdata, slot);

  // peripheral side
  modport dst (input rd, wr, addr, wdata, slot);

endinterface

`default_nettype wire

// ==== design/io_pkg.sv ====
`default_nettype none

package io_pkg;

  // word size shared by data and address
  localparam int IO_W = 16;

  typedef logic [IO_W-1:0] io_word_t;

  // one-hot address bit positions
  localparam int IO_BIT_GPIO_DATA  = 0;  // gpio pins / output data
  localparam int IO_BIT_GPIO_DIR   = 1;  // gpio direction, 1 = output
  localparam int IO_BIT_TASK_BASE  = 8;  // slot 1 xt, slot 2 at 9, slot 3 at 10
  localparam int IO_BIT_TASK_FETCH = 14; // read: task fetch, write: kill request
  localparam int IO_BIT_MASK_SLOT  = 15; // read: slot id, write: mask set

  // default mask, every bit passes
  localparam io_word_t IO_MASK_ALL = '1;

endpackage

`default_nettype wire

// ==== design/io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_top import io_pkg::*; #(
  parameter int NUM_SLOTS = 4,
  parameter int GPIO_W    = 16
) (
  input  logic                         clk,
  input  logic                         resetq,
  input  logic                         io_rd,
  input  logic                         io_wr,
  input  io_word_t                     io_addr,    // one-hot
  input  io_word_t                     io_wdata,
  input  logic [$clog2(NUM_SLOTS)-1:0] io_slot,
  output io_word_t                     io_rdata,   // valid the cycle after the strobe
  input  logic [GPIO_W-1:0]            gpio_in,
  output logic [GPIO_W-1:0]            gpio_out,
  output logic [GPIO_W-1:0]            gpio_oe,
  output logic [NUM_SLOTS-1:0]         kill_slot_rq
);

  io_word_t mask;        // current mask of the slot on the bus
  io_word_t gpio_rdata;
  io_word_t task_rdata;

  io_bus_if #(.NUM_SLOTS(NUM_SLOTS)) bus ();

  io_access_stage #(.NUM_SLOTS(NUM_SLOTS)) u_stage (
    .clk      (clk),
    .resetq   (resetq),
    .io_rd    (io_rd),
    .io_wr    (io_wr),
    .io_addr  (io_addr),
    .io_wdata (io_wdata),
    .io_slot  (io_slot),
    .bus      (bus.src)
  );

  io_access_mask #(.NUM_SLOTS(NUM_SLOTS)) u_mask (
    .clk        (clk),
    .resetq     (resetq),
    .bus        (bus.dst),
    .gpio_rdata (gpio_rdata),
    .task_rdata (task_rdata),
    .mask       (mask),
    .rdata      (io_rdata)
  );

  // gpio direction register lives with the pin logic
  gpio_port #(.GPIO_W(GPIO_W)) u_gpio (
    .clk      (clk),
    .resetq   (resetq),
    .bus      (bus.dst),
    .mask     (mask),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .rdata    (gpio_rdata)
  );

  // task regs sit next to the slots they steer
  task_sched_regs #(.NUM_SLOTS(NUM_SLOTS)) u_task (
    .clk          (clk),
    .resetq       (resetq),
    .bus          (bus.dst),
    .rdata        (task_rdata),
    .kill_slot_rq (kill_slot_rq)
  );

endmodule

`default_nettype wire

// ==== design/task_sched_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module task_sched_regs import io_pkg::*; #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                 clk,
  input  logic                 resetq,
  io_bus_if.dst                bus,
  output io_word_t             rdata,
  output logic [NUM_SLOTS-1:0] kill_slot_rq
);

  localparam int SLOT_W = $clog2(NUM_SLOTS);

  io_word_t xt [1:NUM_SLOTS-1];  // slot 0 always starts from zero
  io_word_t xt_raw;              // xt readback at bits 8 and up
  io_word_t fetch_xt;            // xt of the accessing slot
  logic     fetch_rd;

  assign fetch_rd = bus.rd & bus.addr[IO_BIT_TASK_FETCH];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      // stops every slot, else they'd restart their tasks after reset
      for (int i = 1; i < NUM_SLOTS; i++) begin
        xt[i] <= '0;
      end
      kill_slot_rq <= '0;
    end else if (bus.wr) begin
      // any slot may schedule any other
      for (int i = 1; i < NUM_SLOTS; i++) begin
        if (bus.addr[IO_BIT_TASK_BASE + i - 1])
          xt[i] <= bus.wdata;
      end
      // kill request lasts until the next write
      if (bus.addr[IO_BIT_TASK_FETCH])
        kill_slot_rq <= bus.wdata[NUM_SLOTS-1:0];
      else
        kill_slot_rq <= '0;
    end else if (fetch_rd) begin
      for (int i = 1; i < NUM_SLOTS; i++) begin
        // bit 0 set means run once, clear after fetch
        if (bus.slot == SLOT_W'(i) && xt[i][0])
          xt[i] <= '0;
      end
    end
  end

  always_comb begin
    xt_raw   = '0;
    fetch_xt = '0;   // slot 0 gets zero
    for (int i = 1; i < NUM_SLOTS; i++) begin
      if (bus.addr[IO_BIT_TASK_BASE + i - 1])
        xt_raw = xt_raw | xt[i];
      if (bus.slot == SLOT_W'(i))
        fetch_xt = {xt[i][IO_W-1:1], 1'b0};  // valid xts are even
    end
  end

  assign rdata = xt_raw | (bus.addr[IO_BIT_TASK_FETCH] ? fetch_xt : '0);

endmodule

`default_nettype wire

// ==== project.f ====
design/io_pkg.sv
design/io_bus_if.sv
design/io_access_stage.sv
design/io_access_mask.sv
design/gpio_port.sv
design/task_sched_regs.sv
design/io_top.sv
tests/tb_clock.sv
tests/tb_top.sv

// ==== tests/io_input.txt ====
// op (0 idle, 1 read, 2 write) slot addr wdata gpio_in, then expected rdata gpio_out gpio_oe kill
// rdata is checked on reads only, outputs are checked two cycles after the strobe
0001 0001 4000 0000 00f0 0000 0000 0000 0000 // fetch by slot 1, nothing scheduled
0001 0000 4000 0000 00f0 0000 0000 0000 0000
0001 0002 8000 0000 00f0 0002 0000 0000 0000 // slot id
0002 0000 0002 00ff 00f0 0000 0000 00ff 0000
0002 0000 0001 1234 00f0 0000 1234 00ff 0000
0002 0001 8000 000f 00f0 0000 1234 00ff 0000 // slot 1 arms mask 000f
0002 0001 0001 abcd 00f0 0000 00fd 00ff 0000 // masked bits from gpio_in
0002 0001 0001 5555 00f0 0000 5555 00ff 0000 // mask used up
0002 0002 8000 0f00 00f0 0000 5555 00ff 0000
0002 0003 0002 ff00 00f0 0000 5555 ff00 0000 // slot 3 not hit by slot 2 mask
0002 0002 0002 00ff 00f0 0000 5555 f000 0000
0002 0001 8000 00f0 00f0 0000 5555 f000 0000
0001 0001 0001 0000 a5c3 00c0 5555 f000 0000 // read under mask 00f0
0001 0001 0002 0000 00f0 f000 5555 f000 0000
0001 0003 8000 0000 00f0 0003 5555 f000 0000
0002 0000 0100 0201 00f0 0000 5555 f000 0000 // xt1 run once
0002 0000 0200 0400 00f0 0000 5555 f000 0000 // xt2 normal
0001 0001 0100 0000 00f0 0201 5555 f000 0000
0001 0001 4000 0000 00f0 0200 5555 f000 0000
0001 0001 4000 0000 00f0 0000 5555 f000 0000
0001 0002 4000 0000 00f0 0400 5555 f000 0000
0001 0002 4000 0000 00f0 0400 5555 f000 0000
0001 0000 4000 0000 00f0 0000 5555 f000 0000
0002 0003 4000 0006 00f0 0000 5555 f000 0006 // kill request
0000 0000 0000 0000 00f0 0000 5555 f000 0006
0002 0000 0400 0800 00f0 0000 5555 f000 0000 // next write clears it
0001 0003 4000 0000 00f0 0800 5555 f000 0000

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock
module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;  // half period high, half low

endmodule

`default_nettype wire

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top import io_pkg::*; ();

  localparam int NUM_SLOTS  = 4;
  localparam int GPIO_W     = 16;
  localparam int SLOT_W     = $clog2(NUM_SLOTS);
  localparam int CLK_PERIOD = 100;
  localparam int MAX_LINES  = 64;

  // fields of one vector line in file order
  localparam int NF       = 9;
  localparam int F_OP     = 0;
  localparam int F_SLOT   = 1;
  localparam int F_ADDR   = 2;
  localparam int F_WDATA  = 3;
  localparam int F_GPIN   = 4;
  localparam int F_RDATA  = 5;
  localparam int F_OUT    = 6;
  localparam int F_OE     = 7;
  localparam int F_KILL   = 8;

  localparam io_word_t OP_READ  = 16'h0001;
  localparam io_word_t OP_WRITE = 16'h0002;
  localparam io_word_t OP_END   = 16'hffff;  // unfilled entries

  logic                 clk;
  logic                 resetq;
  logic                 io_rd;
  logic                 io_wr;
  io_word_t             io_addr;
  io_word_t             io_wdata;
  logic [SLOT_W-1:0]    io_slot;
  io_word_t             io_rdata;
  logic [GPIO_W-1:0]    gpio_in;
  logic [GPIO_W-1:0]    gpio_out;
  logic [GPIO_W-1:0]    gpio_oe;
  logic [NUM_SLOTS-1:0] kill_slot_rq;

  io_word_t vec [MAX_LINES*NF];  // flat vector store
  int       num_lines;
  bit       loaded;                // watchdog starts once the vectors are in

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

  io_top #(.NUM_SLOTS(NUM_SLOTS), .GPIO_W(GPIO_W)) dut (
    .clk          (clk),
    .resetq       (resetq),
    .io_rd        (io_rd),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_wdata     (io_wdata),
    .io_slot      (io_slot),
    .io_rdata     (io_rdata),
    .gpio_in      (gpio_in),
    .gpio_out     (gpio_out),
    .gpio_oe      (gpio_oe),
    .kill_slot_rq (kill_slot_rq)
  );

  task automatic check_value(input string what, input io_word_t got, input io_word_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // put one line's access on the cpu side pins
  task automatic apply_vector(input int idx);
    int b;
    b = idx * NF;
    io_rd    = (vec[b + F_OP] == OP_READ);
    io_wr    = (vec[b + F_OP] == OP_WRITE);
    io_slot  = vec[b + F_SLOT][SLOT_W-1:0];
    io_addr  = vec[b + F_ADDR];
    io_wdata = vec[b + F_WDATA];
    gpio_in  = vec[b + F_GPIN][GPIO_W-1:0];
  endtask

  task automatic park_bus();
    io_rd   = 1'b0;
    io_wr   = 1'b0;
    io_addr = '0;   // gpio_in holds its last value
  endtask

  initial begin : stimulus
    int k;
    int b;
    resetq    = 1'b0;
    io_rd     = 1'b0;
    io_wr     = 1'b0;
    io_addr   = '0;
    io_wdata  = '0;
    io_slot   = '0;
    gpio_in   = '0;
    loaded    = 1'b0;
    num_lines = 0;
    for (k = 0; k < MAX_LINES*NF; k++) begin
      vec[k] = OP_END;
    end
    $readmemh("tests/io_input.txt", vec);
    while (num_lines < MAX_LINES && vec[num_lines*NF + F_OP] != OP_END) begin
      num_lines++;
    end
    loaded = 1'b1;

    repeat (8) @(posedge clk);
    @(negedge clk);
    resetq = 1'b1;
    @(negedge clk);
    // everything quiet out of reset
    check_value("gpio_out after reset", io_word_t'(gpio_out), '0);
    check_value("gpio_oe after reset", io_word_t'(gpio_oe), '0);
    check_value("kill_slot_rq after reset", io_word_t'(kill_slot_rq), '0);

    // each negedge checks the read of line k-1 and the state after line k-2
    // before line k goes out
    for (k = 0; k < num_lines + 2; k++) begin
      @(negedge clk);
      if (k >= 1 && vec[(k-1)*NF + F_OP] == OP_READ) begin
        check_value($sformatf("line %0d io_rdata", k - 1), io_rdata,
                    vec[(k-1)*NF + F_RDATA]);
      end
      if (k >= 2) begin
        b = (k - 2) * NF;
        check_value($sformatf("line %0d gpio_out", k - 2), io_word_t'(gpio_out),
                    vec[b + F_OUT]);
        check_value($sformatf("line %0d gpio_oe", k - 2), io_word_t'(gpio_oe),
                    vec[b + F_OE]);
        check_value($sformatf("line %0d kill_slot_rq", k - 2),
                    io_word_t'(kill_slot_rq), vec[b + F_KILL]);
      end
      if (k < num_lines)
        apply_vector(k);
      else
        park_bus();   // drain the last two lines
    end

    $display("all tests passed");
    $finish;
  end

  // reset, vectors and pipeline drain all fit in lines + 20 cycles
  initial begin : watchdog
    wait (loaded);
    #((num_lines + 20) * CLK_PERIOD);
    $display("timeout: %0d vector lines did not finish in %0d cycles",
             num_lines, num_lines + 20);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
